//--- Makefile
VERILATOR  ?= verilator
TOP        := pinballFieldTb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/pinballFieldTb.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module pinballFieldTb;
	import fieldGeomPkg::*;
	import ballPhysPkg::*;

	localparam int FRAME_LEN = `FIELD_SIZE_X * `FIELD_SIZE_Y;
	localparam int NUM_FRAMES = 140;

	logic clk;
	logic resetN;
	logic pause;
	logic levelReset;
	pixelCoord_t ballPos;
	logic frameStart;
	collisionEvent_t collisionEvent;

	// model state, fixed point like the ball controller
	int mVx, mVy, mPx, mPy, mCool;
	pixelCoord_t prevPos, curPos;
	int posErrors, eventErrors, startErrors, otherErrors;
	int seed = 32'h2822_ac5d;
	bit curPause, curReset, timedOut, sawBottom, sawBumper;

	pinballField u_pinballField (
		.clk            (clk),
		.resetN         (resetN),
		.pause          (pause),
		.levelReset     (levelReset),
		.ballPos        (ballPos),
		.frameStart     (frameStart),
		.collisionEvent (collisionEvent)
	);

	bind ballController pinballField_assert u_pinballFieldAssert (
		.clk            (clk),
		.resetN         (resetN),
		.startOfFrame   (startOfFrame),
		.levelReset     (levelReset),
		.ballPos        (ballPos),
		.collisionEvent (collisionEvent)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic pixelCoord_t fixedToPixel();
		pixelCoord_t p;
		p.x = 11'(mPx / `FIXED_POINT_MULTIPLIER);
		p.y = 11'(mPy / `FIXED_POINT_MULTIPLIER);
		return p;
	endfunction

	// event the merger should report for one scanned pixel
	function automatic collisionEvent_t pixelEvent(int px, int py, pixelCoord_t pos);
		int ox, oy;
		collisionEvent_t ev;
		ox = px - int'(pos.x);
		oy = py - int'(pos.y);
		ev = '0;
		if (ox >= 0 && ox < `BALL_SIZE && oy >= 0 && oy < `BALL_SIZE) begin
			ev.edgeCode = {ox < `BALL_SIZE / 4, oy < `BALL_SIZE / 4,
				ox >= 3 * `BALL_SIZE / 4, oy >= 3 * `BALL_SIZE / 4};
			ev.frameHit = (px == 0) || (px == `FIELD_SIZE_X - 1) ||
				(py == 0) || (py == `FIELD_SIZE_Y - 1);
			for (int i = `NUM_BUMPERS - 1; i >= 0; i--) begin
				if (px >= int'(BUMPER_RECTS[i].topLeft.x) &&
						px <= int'(BUMPER_RECTS[i].bottomRight.x) &&
						py >= int'(BUMPER_RECTS[i].topLeft.y) &&
						py <= int'(BUMPER_RECTS[i].bottomRight.y)) begin
					ev.bumperHit = 1'b1;
					ev.factor = BUMPER_FACTORS[i]; // lowest index ends up last
				end
			end
		end
		return ev;
	endfunction

	function automatic void applyEvent(collisionEvent_t ev);
		int nvx, nvy;
		if (ev.frameHit) begin
			if (ev.edgeCode[2] && mVy < 0)
				mVy = -mVy;
			else if (ev.edgeCode[0] && mVy > 0)
				mVy = -mVy;
			if (ev.edgeCode[3] && mVx < 0)
				mVx = -mVx;
			else if (ev.edgeCode[1] && mVx > 0)
				mVx = -mVx;
		end else if (ev.bumperHit && mCool == 0) begin
			nvx = (mVx * int'(ev.factor.xx) + mVy * int'(ev.factor.yx)) >>> 1;
			nvy = (mVy * int'(ev.factor.yy) + mVx * int'(ev.factor.xy)) >>> 1;
			mVx = nvx;
			mVy = nvy;
			mCool = `BUMPER_COOLDOWN;
		end
	endfunction

	// one frame of the playfield, returns the position shown during it
	function automatic pixelCoord_t modelFrame(bit doPause, bit doReset);
		pixelCoord_t oldPos, newPos;
		oldPos = fixedToPixel();
		if (doReset) begin
			mVx = 0;
			mVy = 0;
			mCool = 0;
			mPx = `BALL_INIT_X * `FIXED_POINT_MULTIPLIER;
			mPy = `BALL_INIT_Y * `FIXED_POINT_MULTIPLIER;
			return fixedToPixel();
		end
		if (doPause)
			return oldPos;
		mPy = mPy + mVy;
		mVy = mVy + `GRAVITY;
		if (mPx + mVx < 0 ||
				mPx + mVx > (`FIELD_SIZE_X - `BALL_SIZE) * `FIXED_POINT_MULTIPLIER)
			mVx = mVx >>> 1;
		else
			mPx = mPx + mVx;
		if (mCool != 0)
			mCool = mCool - 1;
		// last pixel and pixel (0,0) were scanned at the old position
		applyEvent(pixelEvent(`FIELD_SIZE_X - 1, `FIELD_SIZE_Y - 1, oldPos));
		applyEvent(pixelEvent(0, 0, oldPos));
		newPos = fixedToPixel();
		for (int k = 1; k <= FRAME_LEN - 3; k++)
			applyEvent(pixelEvent(k % `FIELD_SIZE_X, k / `FIELD_SIZE_X, newPos));
		return newPos; // second to last pixel lands on the frame step
	endfunction

	// event seen in cycle c of the frame, two pixels behind the raster
	function automatic collisionEvent_t expectedEvent(int c);
		if (c == 0)
			return pixelEvent(`FIELD_SIZE_X - 2, `FIELD_SIZE_Y - 1, prevPos);
		if (c == 1)
			return pixelEvent(`FIELD_SIZE_X - 1, `FIELD_SIZE_Y - 1, prevPos);
		if (c == 2)
			return pixelEvent(0, 0, prevPos);
		return pixelEvent((c - 2) % `FIELD_SIZE_X, (c - 2) / `FIELD_SIZE_X, curPos);
	endfunction

	task automatic checkPos(pixelCoord_t got, pixelCoord_t exp, int frame);
		if (got !== exp) begin
			posErrors++;
			$display("Error %0t: frame %0d ballPos (%0d,%0d), expected (%0d,%0d)",
				$time, frame, got.x, got.y, exp.x, exp.y);
		end
	endtask

	task automatic checkEvent(collisionEvent_t got, collisionEvent_t exp, int frame, int c);
		if (got !== exp) begin
			eventErrors++;
			if (eventErrors <= 20)
				$display("Error %0t: frame %0d cycle %0d event %h, expected %h",
					$time, frame, c, got, exp);
		end
	endtask

	task automatic checkFrameStart(logic got, logic exp, int frame, int c);
		if (got !== exp) begin
			startErrors++;
			if (startErrors <= 20)
				$display("Error %0t: frame %0d cycle %0d frameStart %b, expected %b",
					$time, frame, c, got, exp);
		end
	endtask

	// returns mid cycle, in the frame start cycle
	task automatic waitFrameStart(output bit ok, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!frameStart && cycles < 2 * FRAME_LEN);
		ok = frameStart;
	endtask

	initial begin
		bit ok;
		int waited;
		pause = 1'b1;
		levelReset = 1'b0;
		resetN = 1'b1;
		curPause = 1'b1;
		curReset = 1'b0;
		void'(modelFrame(1'b0, 1'b1)); // reset state
		curPos = fixedToPixel();
		@(posedge clk);
		resetN <= 1'b0;
		repeat (8) @(posedge clk);
		resetN <= 1'b1;

		for (int f = 0; f < NUM_FRAMES; f++) begin
			prevPos = curPos;
			curPos = modelFrame(curPause, curReset);
			waitFrameStart(ok, waited);
			if (!ok) begin
				timedOut = 1'b1;
				break;
			end
			if (f > 0 && waited != 1) begin
				startErrors++;
				$display("Error %0t: frame %0d started %0d cycles late",
					$time, f, waited - 1);
			end
			checkEvent(collisionEvent, expectedEvent(0), f, 0);
			for (int c = 1; c < FRAME_LEN; c++) begin
				@(negedge clk);
				if (c == 1)
					checkPos(ballPos, curPos, f);
				checkFrameStart(frameStart, 1'b0, f, c);
				checkEvent(collisionEvent, expectedEvent(c), f, c);
				if (collisionEvent.frameHit && collisionEvent.edgeCode[0])
					sawBottom = 1'b1;
				if (collisionEvent.bumperHit)
					sawBumper = 1'b1;
			end
			// inputs for the next frame
			curReset = (f + 1 == 100) ||
				((f + 1 > 105) && (($random(seed) & 31) == 0));
			curPause = !curReset &&
				((f + 1 < 4) || (($random(seed) & 15) == 0));
			@(posedge clk);
			pause <= curPause;
			levelReset <= curReset;
		end

		if (!timedOut && !sawBottom) begin
			otherErrors++;
			$display("The ball never reached the bottom wall");
		end
		if (!timedOut && !sawBumper) begin
			otherErrors++;
			$display("The ball never hit a bumper");
		end
		if (timedOut) begin
			otherErrors++;
			$display("Timed out waiting for the start of a frame");
		end
		$display("Summary: %0d position, %0d event, %0d frame start mismatches, %0d other failures",
			posErrors, eventErrors, startErrors, otherErrors);
		if (posErrors + eventErrors + startErrors + otherErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- dv/pinballField_assert.sv
`timescale 1ns/1ps

module pinballField_assert (
	input logic                         clk,
	input logic                         resetN,
	input logic                         startOfFrame,
	input logic                         levelReset,
	input fieldGeomPkg::pixelCoord_t    ballPos,
	input ballPhysPkg::collisionEvent_t collisionEvent
);

	// frame start lasts one pixel
	framePulse: assert property (
		@(posedge clk) disable iff (!resetN)
		startOfFrame |=> !startOfFrame
	) else $error("startOfFrame held for more than one cycle");

	// position only moves on a frame step or a level reset
	posStable: assert property (
		@(posedge clk) disable iff (!resetN)
		$changed(ballPos) |-> ($past(startOfFrame) || $past(levelReset))
	) else $error("ballPos changed outside a frame step");

	// detector and delay stages come out of reset empty
	noEventInReset: assert property (
		@(posedge clk)
		!resetN |-> ##2 (collisionEvent == '0)
	) else $error("collision event during reset");

endmodule

//--- files.f
+incdir+rtl
rtl/fieldGeomPkg.sv
rtl/ballPhysPkg.sv
rtl/fieldRaster.sv
rtl/bumperHitDetector.sv
rtl/collisionMerger.sv
rtl/ballController.sv
rtl/pinballField.sv
dv/pinballField_assert.sv
dv/pinballFieldTb.sv

//--- rtl/ballController.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module ballController (
	input  logic                         clk,
	input  logic                         resetN,
	input  logic                         startOfFrame,
	input  logic                         pause,
	input  logic                         levelReset,
	input  ballPhysPkg::collisionEvent_t collisionEvent,
	output fieldGeomPkg::pixelCoord_t    ballPos
);
	import ballPhysPkg::*;

	speed_t xSpeed;
	speed_t ySpeed;
	logic signed [31:0] posXFixed;
	logic signed [31:0] posYFixed;
	logic [7:0] bumperCooldown;
	logic [3:0] edgeCode;
	logic bumperAccepted;

	// {left, top, right, bottom}
	assign edgeCode = collisionEvent.edgeCode;

	// walls take priority over bumpers
	assign bumperAccepted = collisionEvent.bumperHit && !collisionEvent.frameHit &&
		(bumperCooldown == 8'd0);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bumperCooldown <= '0;
		end else if (levelReset) begin
			bumperCooldown <= '0;
		end else if (!pause) begin
			if (startOfFrame) begin
				if (bumperCooldown != 8'd0)
					bumperCooldown <= bumperCooldown - 8'd1;
			end else if (bumperAccepted) begin
				bumperCooldown <= 8'(`BUMPER_COOLDOWN);
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ySpeed    <= '0;
			posYFixed <= `BALL_INIT_Y * `FIXED_POINT_MULTIPLIER;
		end else if (levelReset) begin
			ySpeed    <= '0;
			posYFixed <= `BALL_INIT_Y * `FIXED_POINT_MULTIPLIER;
		end else if (!pause) begin
			if (startOfFrame) begin
				ySpeed    <= ySpeed + `GRAVITY;
				posYFixed <= posYFixed + ySpeed;
			end else if (collisionEvent.frameHit) begin
				if (edgeCode[2] && (ySpeed < 0))
					ySpeed <= -ySpeed;
				else if (edgeCode[0] && (ySpeed > 0))
					ySpeed <= -ySpeed;
			end else if (bumperAccepted) begin
				ySpeed <= (ySpeed * speed_t'(collisionEvent.factor.yy) +
					xSpeed * speed_t'(collisionEvent.factor.xy)) >>> 1;
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xSpeed    <= '0;
			posXFixed <= `BALL_INIT_X * `FIXED_POINT_MULTIPLIER;
		end else if (levelReset) begin
			xSpeed    <= '0;
			posXFixed <= `BALL_INIT_X * `FIXED_POINT_MULTIPLIER;
		end else if (!pause) begin
			if (startOfFrame) begin
				// bleed off speed rather than leave the field sideways
				if (posXFixed + xSpeed < 0)
					xSpeed <= xSpeed >>> 1;
				else if (posXFixed + xSpeed >
						(`FIELD_SIZE_X - `BALL_SIZE) * `FIXED_POINT_MULTIPLIER)
					xSpeed <= xSpeed >>> 1;
				else
					posXFixed <= posXFixed + xSpeed;
			end else if (collisionEvent.frameHit) begin
				if (edgeCode[3] && (xSpeed < 0))
					xSpeed <= -xSpeed;
				else if (edgeCode[1] && (xSpeed > 0))
					xSpeed <= -xSpeed;
			end else if (bumperAccepted) begin
				xSpeed <= (xSpeed * speed_t'(collisionEvent.factor.xx) +
					ySpeed * speed_t'(collisionEvent.factor.yx)) >>> 1;
			end
		end
	end

	always_comb begin
		ballPos.x = 11'(posXFixed / `FIXED_POINT_MULTIPLIER);
		ballPos.y = 11'(posYFixed / `FIXED_POINT_MULTIPLIER);
	end

endmodule

//--- rtl/ballPhysPkg.sv
`include "pinball_macros.svh"

package ballPhysPkg;

	// fixed point, 1/64 pixel per frame
	typedef logic signed [31:0] speed_t;

	// new speeds are (xx*vx + yx*vy)/2 and (yy*vy + xy*vx)/2
	typedef struct packed {
		logic signed [3:0] xx;
		logic signed [3:0] xy;
		logic signed [3:0] yx;
		logic signed [3:0] yy;
	} collisionFactor_t;

	typedef struct packed {
		logic             frameHit;
		logic             bumperHit;
		logic [3:0]       edgeCode;
		collisionFactor_t factor;
	} collisionEvent_t;

	localparam fieldGeomPkg::rect_t BUMPER_RECTS [`NUM_BUMPERS] = '{
		'{topLeft: '{x: 11'sd30, y: 11'sd26}, bottomRight: '{x: 11'sd33, y: 11'sd29}},
		'{topLeft: '{x: 11'sd4, y: 11'sd10}, bottomRight: '{x: 11'sd9, y: 11'sd15}},
		'{topLeft: '{x: 11'sd50, y: 11'sd20}, bottomRight: '{x: 11'sd55, y: 11'sd25}}
	};

	localparam collisionFactor_t BUMPER_FACTORS [`NUM_BUMPERS] = '{
		'{xx: 4'sd2, xy: 4'sd0, yx: 4'sd1, yy: -4'sd2},  // kicks right and back up
		'{xx: -4'sd2, xy: 4'sd1, yx: 4'sd0, yy: -4'sd2},
		'{xx: -4'sd2, xy: 4'sd0, yx: -4'sd1, yy: 4'sd1}
	};

endpackage

//--- rtl/bumperHitDetector.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module bumperHitDetector #(
	parameter int bumperIndex = 0
) (
	input  logic                     clk,
	input  logic                     resetN,
	input  fieldGeomPkg::scanPixel_t scanPixel,
	output logic                     hit
);
	import fieldGeomPkg::*;
	import ballPhysPkg::*;

	// this instance's bumper
	localparam rect_t bumperRect = BUMPER_RECTS[bumperIndex];

	logic insideX;
	logic insideY;
	logic hitNext;

	always_comb begin
		insideX = (scanPixel.coord.x >= bumperRect.topLeft.x) &&
			(scanPixel.coord.x <= bumperRect.bottomRight.x);
		insideY = (scanPixel.coord.y >= bumperRect.topLeft.y) &&
			(scanPixel.coord.y <= bumperRect.bottomRight.y);

		// only ball pixels count
		hitNext = scanPixel.inBall && insideX && insideY;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit <= 1'b0;
		end else begin
			hit <= hitNext;
		end
	end

endmodule

//--- rtl/collisionMerger.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module collisionMerger (
	input  logic                         clk,
	input  logic                         resetN,
	input  fieldGeomPkg::scanPixel_t     scanPixel,
	input  logic [`NUM_BUMPERS-1:0]      hits,
	output ballPhysPkg::collisionEvent_t collisionEvent
);
	import fieldGeomPkg::*;
	import ballPhysPkg::*;

	scanPixel_t scanPixelDelayed; // same pixel as the detector hits
	collisionFactor_t factor;
	logic wallHit;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			scanPixelDelayed <= '0;
		end else begin
			scanPixelDelayed <= scanPixel;
		end
	end

	// lowest index wins, so walk down
	always_comb begin
		factor = '0;
		for (int i = `NUM_BUMPERS - 1; i >= 0; i--) begin
			if (hits[i])
				factor = BUMPER_FACTORS[i];
		end
	end

	assign wallHit = scanPixelDelayed.inBall && (
		(scanPixelDelayed.coord.x == 11'sd0) ||
		(scanPixelDelayed.coord.x == 11'(`FIELD_SIZE_X - 1)) ||
		(scanPixelDelayed.coord.y == 11'sd0) ||
		(scanPixelDelayed.coord.y == 11'(`FIELD_SIZE_Y - 1)));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			collisionEvent <= '0;
		end else begin
			collisionEvent.frameHit  <= wallHit;
			collisionEvent.bumperHit <= |hits;
			collisionEvent.edgeCode  <= scanPixelDelayed.edgeCode;
			collisionEvent.factor    <= factor;
		end
	end

endmodule

//--- rtl/fieldGeomPkg.sv
package fieldGeomPkg;

	// signed so that offsets can go negative
	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} pixelCoord_t;

	// both corners inclusive
	typedef struct packed {
		pixelCoord_t topLeft;
		pixelCoord_t bottomRight;
	} rect_t;

	// one raster pixel with its ball mask
	typedef struct packed {
		pixelCoord_t coord;
		logic        inBall;
		logic [3:0]  edgeCode; // {left, top, right, bottom}
	} scanPixel_t;

endpackage

//--- rtl/fieldRaster.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module fieldRaster (
	input  logic                      clk,
	input  logic                      resetN,
	input  fieldGeomPkg::pixelCoord_t ballPos,
	output fieldGeomPkg::scanPixel_t  scanPixel,
	output logic                      startOfFrame
);
	import fieldGeomPkg::*;

	pixelCoord_t pixel;
	logic signed [10:0] offsetX;
	logic signed [10:0] offsetY;
	logic inBall;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			// parked on the last pixel, so (0,0) opens the first frame
			pixel.x <= 11'(`FIELD_SIZE_X - 1);
			pixel.y <= 11'(`FIELD_SIZE_Y - 1);
		end else if (pixel.x == 11'(`FIELD_SIZE_X - 1)) begin
			pixel.x <= '0;
			pixel.y <= (pixel.y == 11'(`FIELD_SIZE_Y - 1)) ? '0 : pixel.y + 11'sd1;
		end else begin
			pixel.x <= pixel.x + 11'sd1;
		end
	end

	always_comb begin
		offsetX = pixel.x - ballPos.x;
		offsetY = pixel.y - ballPos.y;
		inBall = (offsetX >= 0) && (offsetX < `BALL_SIZE) &&
			(offsetY >= 0) && (offsetY < `BALL_SIZE);

		scanPixel.coord       = pixel;
		scanPixel.inBall      = inBall;
		scanPixel.edgeCode[3] = inBall && (offsetX < `BALL_SIZE / 4);        // left
		scanPixel.edgeCode[2] = inBall && (offsetY < `BALL_SIZE / 4);        // top
		scanPixel.edgeCode[1] = inBall && (offsetX >= 3 * `BALL_SIZE / 4);   // right
		scanPixel.edgeCode[0] = inBall && (offsetY >= 3 * `BALL_SIZE / 4);   // bottom
	end

	assign startOfFrame = (pixel.x == 11'sd0) && (pixel.y == 11'sd0);

endmodule

//--- rtl/pinballField.sv
`timescale 1ns/1ps
`include "pinball_macros.svh"

module pinballField (
	input  logic                         clk,
	input  logic                         resetN,
	input  logic                         pause,
	input  logic                         levelReset,
	output fieldGeomPkg::pixelCoord_t    ballPos,
	output logic                         frameStart,
	output ballPhysPkg::collisionEvent_t collisionEvent
);
	import fieldGeomPkg::*;

	scanPixel_t scanPixel;
	logic [`NUM_BUMPERS-1:0] bumperHits;

	fieldRaster u_fieldRaster (
		.clk          (clk),
		.resetN       (resetN),
		.ballPos      (ballPos),
		.scanPixel    (scanPixel),
		.startOfFrame (frameStart)
	);

	// one detector per bumper
	for (genvar i = 0; i < `NUM_BUMPERS; i++) begin : bumperGen
		bumperHitDetector #(
			.bumperIndex (i)
		) u_bumperHitDetector (
			.clk       (clk),
			.resetN    (resetN),
			.scanPixel (scanPixel),
			.hit       (bumperHits[i])
		);
	end

	collisionMerger u_collisionMerger (
		.clk            (clk),
		.resetN         (resetN),
		.scanPixel      (scanPixel),
		.hits           (bumperHits),
		.collisionEvent (collisionEvent)
	);

	ballController u_ballController (
		.clk            (clk),
		.resetN         (resetN),
		.startOfFrame   (frameStart),
		.pause          (pause),
		.levelReset     (levelReset),
		.collisionEvent (collisionEvent),
		.ballPos        (ballPos)
	);

endmodule

//--- rtl/pinball_macros.svh
`ifndef PINBALL_MACROS_SVH
`define PINBALL_MACROS_SVH

// playfield in pixels
`define FIELD_SIZE_X 64
`define FIELD_SIZE_Y 48

// positions are kept in 1/64 pixel units
`define FIXED_POINT_MULTIPLIER 64

// added to the Y speed once per frame
`define GRAVITY 8

// ball box side
`define BALL_SIZE 8

// top left corner after reset
`define BALL_INIT_X 28
`define BALL_INIT_Y 4

`define NUM_BUMPERS 3

// frames of deaf time after a bumper kick
`define BUMPER_COOLDOWN 40

`endif
